/* list.f */
verilog/gat_pkg.sv
verilog/wh_bram.sv
verilog/wh_fetch.sv
verilog/dmvm.sv
verilog/coef_fifo.sv
verilog/gat_attention_top.sv
testbench/tb_gat_attention.sv

/* Makefile */
# Verilator build and run for the GAT attention subsystem

SIM      := verilator
FLAGS    := --binary --timing -j 0 -Wno-fatal
TOP      := tb_gat_attention
FILELIST := list.f
MDIR     := obj_dir
BIN      := $(MDIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build products"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(MDIR)

/* testbench/tb_gat_attention.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_gat_attention import gat_pkg::*; ();

  localparam int NUM_TESTS    = 8;
  localparam int A_BITS       = A_DEPTH * DATA_WIDTH;
  localparam int FEAT_BITS    = HALF_A_SIZE * WH_DATA_WIDTH;
  localparam int TIMEOUT      = 400;
  localparam int PAUSE_CYCLES = 30;

  logic                clk;
  logic                rst_n;
  logic                wh_wr_en;
  wh_addr_t            wh_wr_addr;
  wh_word_t            wh_wr_data;
  logic                a_vld;
  data_t [A_DEPTH-1:0] a_vec;
  logic                start;
  wh_addr_t            num_rows;
  logic                busy;
  data_t               coef;
  logic                coef_empty;
  logic                coef_rd_en;

  // test table
  logic [A_BITS-1:0]    tc_a     [NUM_TESTS];
  int                   tc_rows  [NUM_TESTS];
  logic [WH_DEPTH-1:0]  tc_flags [NUM_TESTS];
  logic [FEAT_BITS-1:0] tc_feat  [NUM_TESTS][WH_DEPTH];
  bit                   tc_rand  [NUM_TESTS];
  bit                   tc_pause [NUM_TESTS];

  // current run
  logic [A_BITS-1:0]    cur_a;
  int                   cur_rows;
  logic [WH_DEPTH-1:0]  cur_flags;
  logic [FEAT_BITS-1:0] cur_feat [WH_DEPTH];
  int                   exp_q [$];

  integer seed       = 32'had69;
  int     model_hold = 0;
  int     errors     = 0;
  int     checks     = 0;
  int     tests_run  = 0;
  bit     timed_out  = 1'b0;

  gat_attention_top u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_wr_en_i   (wh_wr_en),
    .wh_wr_addr_i (wh_wr_addr),
    .wh_wr_data_i (wh_wr_data),
    .a_vld_i      (a_vld),
    .a_i          (a_vec),
    .start_i      (start),
    .num_rows_i   (num_rows),
    .busy_o       (busy),
    .coef_o       (coef),
    .coef_empty_o (coef_empty),
    .coef_rd_en_i (coef_rd_en)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==================================================
  // reference model
  // ==================================================
  // base 0 is the source half of a, HALF_A_SIZE the neighbour half
  function automatic int dot_half(input logic [A_BITS-1:0] a,
                                  input logic [FEAT_BITS-1:0] feat, input int base);
    int s;
    s = 0;
    for (int k = 0; k < HALF_A_SIZE; k++) begin
      s += $signed(a[(base+k)*DATA_WIDTH +: DATA_WIDTH]) *
           $signed(feat[FEAT_BITS-1-k*WH_DATA_WIDTH -: WH_DATA_WIDTH]);
    end
    return s;
  endfunction

  // wrap to 18 bits, keep bits 17..10, clamp negatives
  function automatic int scale_relu(input int s);
    logic [17:0] w;
    logic [7:0]  c;
    w = s[17:0];
    c = w[17:10];
    return c[7] ? 0 : int'(c);
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what, input int t);
    $display("timeout in test %0d: %s for %0d cycles", t, what, TIMEOUT);
    timed_out = 1'b1;
  endtask

  task automatic set_case(input int idx, input logic [A_BITS-1:0] a, input int rows,
                          input logic [WH_DEPTH-1:0] flags, input bit rnd, input bit pause);
    tc_a[idx]     = a;
    tc_rows[idx]  = rows;
    tc_flags[idx] = flags;
    tc_rand[idx]  = rnd;
    tc_pause[idx] = pause;
  endtask

  task automatic build_table();
    // single source row
    set_case(0, 64'h1E1E1E1E_28282828, 1, 16'h0001, 1'b0, 1'b0);
    tc_feat[0][0] = 32'h14141414;
    // one neighbourhood
    set_case(1, 64'h3C32281E_7F645046, 5, 16'h0001, 1'b0, 1'b0);
    tc_feat[1][0] = 32'h10203040;
    tc_feat[1][1] = 32'h7F010203;
    tc_feat[1][2] = 32'h40404040;
    tc_feat[1][3] = 32'h05506070;
    tc_feat[1][4] = 32'h7F7F7F7F;
    // second source mid-stream
    set_case(2, 64'h0A141E28_32323232, 6, 16'h0009, 1'b0, 1'b0);
    tc_feat[2][0] = 32'h20202020;
    tc_feat[2][1] = 32'h30405060;
    tc_feat[2][2] = 32'h11223344;
    tc_feat[2][3] = 32'h7F7F0000;
    tc_feat[2][4] = 32'h01020304;
    tc_feat[2][5] = 32'h60606060;
    // negative sums and wrap past bit 17
    set_case(3, 64'h80808080_80808080, 4, 16'h0005, 1'b0, 1'b0);
    tc_feat[3][0] = 32'h80808080;
    tc_feat[3][1] = 32'h7F7F7F7F;
    tc_feat[3][2] = 32'h01020304;
    tc_feat[3][3] = 32'hC0C0C0C0;
    // full memory with reads held off
    set_case(4, 64'h19191919_2D2D2D2D, 16, 16'h0101, 1'b0, 1'b1);
    for (int r = 0; r < WH_DEPTH; r++) begin
      tc_feat[4][r] = {8'(r * 9 + 1), 8'(r * 5 - 40), 8'(70 - r * 3), 8'(r * 11)};
    end
    // random runs, a reloaded each time
    for (int i = 5; i < NUM_TESTS; i++) begin
      set_case(i, '0, 0, '0, 1'b1, 1'b0);
    end
  endtask

  // ==================================================
  // bus tasks
  // ==================================================
  task automatic load_inputs();
    for (int r = 0; r < cur_rows; r++) begin
      @(negedge clk);
      a_vld      = (r == 0);
      a_vec      = cur_a;
      wh_wr_en   = 1'b1;
      wh_wr_addr = wh_addr_t'(r);
      wh_wr_data = {cur_feat[r], cur_flags[r]};
    end
    @(negedge clk);
    a_vld    = 1'b0;
    wh_wr_en = 1'b0;
    start    = 1'b1;
    num_rows = wh_addr_t'(cur_rows - 1);
    @(negedge clk);
    start    = 1'b0;
  endtask

  // pop every expected coefficient as it arrives
  task automatic collect(input int t);
    int got_n;
    int idle;
    got_n = 0;
    idle  = 0;
    while (got_n < exp_q.size() && !timed_out) begin
      @(negedge clk);
      coef_rd_en = 1'b0;
      if (!coef_empty) begin
        check($sformatf("coef_o row %0d", got_n), coef, exp_q[got_n]);
        coef_rd_en = 1'b1;
        got_n++;
        idle = 0;
      end else begin
        idle++;
        if (idle > TIMEOUT) begin
          report_timeout("coef_empty_o stayed high", t);
        end
      end
    end
    @(negedge clk);
    coef_rd_en = 1'b0;
  endtask

  task automatic run_test(input int t);
    int err0;
    int src_dot;
    int nbr_dot;
    err0 = errors;
    exp_q.delete();
    if (tc_rand[t]) begin
      cur_a     = {$random(seed), $random(seed)};
      cur_rows  = ($random(seed) & 15) + 1;
      cur_flags = 16'($random(seed));
      for (int r = 0; r < WH_DEPTH; r++) begin
        cur_feat[r] = $random(seed);
      end
    end else begin
      cur_a     = tc_a[t];
      cur_rows  = tc_rows[t];
      cur_flags = tc_flags[t];
      for (int r = 0; r < WH_DEPTH; r++) begin
        cur_feat[r] = tc_feat[t][r];
      end
    end
    // held source carries over from earlier runs
    for (int r = 0; r < cur_rows; r++) begin
      src_dot = dot_half(cur_a, cur_feat[r], 0);
      nbr_dot = dot_half(cur_a, cur_feat[r], HALF_A_SIZE);
      if (cur_flags[r]) begin
        model_hold = src_dot;
      end
      exp_q.push_back(scale_relu(model_hold + nbr_dot));
    end
    load_inputs();
    if (tc_pause[t]) begin
      repeat (PAUSE_CYCLES) @(negedge clk);
      check("busy_o while stalled", busy, 1);
    end
    collect(t);
    // last row went out well before its coefficient came back
    if (!timed_out) begin
      check("busy_o", busy, 0);
      check("coef_empty_o", coef_empty, 1);
    end
    tests_run++;
    $display("test %0d: %0d rows, %0d errors", t, cur_rows, errors - err0);
  endtask

  // ==================================================
  // main sequence
  // ==================================================
  initial begin
    int t;
    rst_n      = 1'b0;
    wh_wr_en   = 1'b0;
    wh_wr_addr = '0;
    wh_wr_data = '0;
    a_vld      = 1'b0;
    a_vec      = '0;
    start      = 1'b0;
    num_rows   = '0;
    coef_rd_en = 1'b0;
    build_table();
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end
    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/gat_attention_top.sv */
`timescale 1ns/1ns
`default_nettype none

module gat_attention_top import gat_pkg::*; (
  input  wire logic                clk,
  input  wire logic                rst_n,
  // wh loading
  input  wire logic                wh_wr_en_i,
  input  wire wh_addr_t            wh_wr_addr_i,
  input  wire wh_word_t            wh_wr_data_i,
  // attention weights
  input  wire logic                a_vld_i,
  input  wire data_t [A_DEPTH-1:0] a_i,
  // run control
  input  wire logic                start_i,
  input  wire wh_addr_t            num_rows_i,
  output logic                     busy_o,
  // coefficients out
  output data_t                    coef_o,
  output logic                     coef_empty_o,
  input  wire logic                coef_rd_en_i
);

  logic      rd_en;
  wh_addr_t  rd_addr;
  wh_word_t  rd_data;
  logic      row_vld;
  logic      wr_en;
  data_t     wr_data;
  fifo_cnt_t free_cnt;

  wh_bram u_wh_bram (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_en_i   (wh_wr_en_i),
    .wr_addr_i (wh_wr_addr_i),
    .wr_data_i (wh_wr_data_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  wh_fetch u_wh_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .start_i    (start_i),
    .num_rows_i (num_rows_i),
    .free_cnt_i (free_cnt),
    .rd_en_o    (rd_en),
    .rd_addr_o  (rd_addr),
    .row_vld_o  (row_vld),
    .busy_o     (busy_o)
  );

  dmvm u_dmvm (
    .clk          (clk),
    .rst_n        (rst_n),
    .row_vld_i    (row_vld),
    .a_vld_i      (a_vld_i),
    .a_i          (a_i),
    .wh_data_i    (rd_data),
    .coef_wr_en_o (wr_en),
    .coef_data_o  (wr_data)
  );

  coef_fifo u_coef_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .rd_en_i    (coef_rd_en_i),
    .rd_data_o  (coef_o),
    .empty_o    (coef_empty_o),
    .free_cnt_o (free_cnt)
  );

endmodule

`default_nettype wire

/* verilog/coef_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module coef_fifo import gat_pkg::*; (
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  wr_en_i,
  input  wire data_t wr_data_i,
  input  wire logic  rd_en_i,
  output data_t      rd_data_o,
  output logic       empty_o,
  output fifo_cnt_t  free_cnt_o
);

  data_t                      mem [COEF_FIFO_DEPTH];
  logic [FIFO_ADDR_WIDTH-1:0] wr_ptr_q;
  logic [FIFO_ADDR_WIDTH-1:0] rd_ptr_q;
  fifo_cnt_t                  count_q;
  logic                       wr_ok;
  logic                       rd_ok;

  assign wr_ok = wr_en_i && (count_q != fifo_cnt_t'(COEF_FIFO_DEPTH));
  assign rd_ok = rd_en_i && !empty_o;

  // head is always visible
  assign rd_data_o  = mem[rd_ptr_q];
  assign empty_o    = (count_q == '0);
  assign free_cnt_o = fifo_cnt_t'(COEF_FIFO_DEPTH) - count_q;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr_q] <= wr_data_i;
    end
  end

  // ==================================================
  // pointers and occupancy
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/dmvm.sv */
`timescale 1ns/1ns
`default_nettype none

module dmvm import gat_pkg::*; (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  row_vld_i,
  input  wire logic                  a_vld_i,
  input  wire data_t [A_DEPTH-1:0]   a_i,
  input  wire wh_word_t              wh_data_i,
  output logic                       coef_wr_en_o,
  output data_t                      coef_data_o
);

  // weights and features
  data_t [A_DEPTH-1:0]     a_q;
  data_t                   a_src [HALF_A_SIZE];
  data_t                   a_nbr [HALF_A_SIZE];
  wh_word_t                row_q;
  data_t                   feat [HALF_A_SIZE];

  // stage 0 products, then adder levels
  acc_t                    src_next  [NUM_STAGES][HALF_A_SIZE];
  acc_t                    nbr_next  [NUM_STAGES][HALF_A_SIZE];
  acc_t                    src_stage [NUM_STAGES][HALF_A_SIZE];
  acc_t                    nbr_stage [NUM_STAGES][HALF_A_SIZE];
  logic [NUM_STAGES-1:0]   flag_stage;

  acc_t                    src_hold_q;
  acc_t                    src_now;
  acc_t                    sum;
  data_t                   scaled;
  data_t                   coef_q;
  logic [COEF_DELAY_LENGTH-1:0] vld_shft_q;

  // ==================================================
  // weight register and row capture
  // ==================================================
  always_ff @(posedge clk) begin
    if (a_vld_i) begin
      a_q <= a_i;
    end
    if (row_vld_i) begin
      row_q <= wh_data_i;
    end
  end

  // lower half of a pairs with the source, upper half with the neighbour
  for (genvar k = 0; k < HALF_A_SIZE; k++) begin : g_split
    assign a_src[k] = a_q[k];
    assign a_nbr[k] = a_q[k+HALF_A_SIZE];
    // element 0 sits at the top of the row word
    assign feat[k]  = row_q[WH_WIDTH-1-k*WH_DATA_WIDTH -: WH_DATA_WIDTH];
  end

  // ==================================================
  // multiplier and adder tree
  // ==================================================
  for (genvar k = 0; k < HALF_A_SIZE; k++) begin : g_mul
    assign src_next[0][k] = $signed(a_src[k]) * $signed(feat[k]);
    assign nbr_next[0][k] = $signed(a_nbr[k]) * $signed(feat[k]);
  end

  for (genvar l = 1; l < NUM_STAGES; l++) begin : g_lvl
    for (genvar k = 0; k < HALF_A_SIZE; k++) begin : g_node
      if (k < (HALF_A_SIZE >> l)) begin : g_add
        assign src_next[l][k] = src_stage[l-1][2*k] + src_stage[l-1][2*k+1];
        assign nbr_next[l][k] = nbr_stage[l-1][2*k] + nbr_stage[l-1][2*k+1];
      end else begin : g_pad
        assign src_next[l][k] = '0;
        assign nbr_next[l][k] = '0;
      end
    end
  end

  always_ff @(posedge clk) begin
    src_stage <= src_next;
    nbr_stage <= nbr_next;
  end

  // source flag rides along with the sums
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flag_stage <= '0;
    end else begin
      flag_stage <= {flag_stage[NUM_STAGES-2:0], row_q[0]};
    end
  end

  // ==================================================
  // source hold, scale and relu
  // ==================================================
  // a valid flagged row replaces the held sum, itself included
  assign src_now = (flag_stage[NUM_STAGES-1] && vld_shft_q[NUM_STAGES]) ?
                   src_stage[NUM_STAGES-1][0] : src_hold_q;
  assign sum     = src_now + nbr_stage[NUM_STAGES-1][0];
  assign scaled  = sum[DMVM_DATA_WIDTH-1 -: DATA_WIDTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      src_hold_q <= '0;
    end else begin
      src_hold_q <= src_now;
    end
  end

  always_ff @(posedge clk) begin
    coef_q <= scaled[DATA_WIDTH-1] ? '0 : scaled;
  end

  // valid delay, one bit per register stage
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_shft_q <= '0;
    end else begin
      vld_shft_q <= {vld_shft_q[COEF_DELAY_LENGTH-2:0], row_vld_i};
    end
  end

  assign coef_wr_en_o = vld_shft_q[COEF_DELAY_LENGTH-1];
  assign coef_data_o  = coef_q;

endmodule

`default_nettype wire

/* verilog/wh_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module wh_fetch import gat_pkg::*; (
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      start_i,
  input  wire wh_addr_t  num_rows_i,
  input  wire fifo_cnt_t free_cnt_i,
  output logic           rd_en_o,
  output wh_addr_t       rd_addr_o,
  output logic           row_vld_o,
  output logic           busy_o
);

  fetch_state_t state_q;
  wh_addr_t     addr_q;
  wh_addr_t     last_q;
  logic         space_ok;
  logic         row_vld_q;

  // only issue when the fifo can absorb every row in flight
  assign space_ok  = free_cnt_i > fifo_cnt_t'(ISSUE_MARGIN);
  assign rd_en_o   = (state_q == FETCH_RUN) && space_ok;
  assign rd_addr_o = addr_q;
  assign busy_o    = (state_q == FETCH_RUN);
  assign row_vld_o = row_vld_q;

  // ==================================================
  // sequencer
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= FETCH_IDLE;
      addr_q  <= '0;
      last_q  <= '0;
    end else begin
      case (state_q)
        // drain cycle may take a new start right away
        FETCH_IDLE, FETCH_DRAIN: begin
          if (start_i) begin
            state_q <= FETCH_RUN;
            addr_q  <= '0;
            last_q  <= num_rows_i;
          end else begin
            state_q <= FETCH_IDLE;
          end
        end
        FETCH_RUN: begin
          if (rd_en_o) begin
            if (addr_q == last_q) begin
              state_q <= FETCH_DRAIN;
            end else begin
              addr_q <= addr_q + 1'b1;
            end
          end
        end
        default: begin
          state_q <= FETCH_IDLE;
        end
      endcase
    end
  end

  // read data shows up one cycle after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      row_vld_q <= 1'b0;
    end else begin
      row_vld_q <= rd_en_o;
    end
  end

endmodule

`default_nettype wire

/* verilog/wh_bram.sv */
`timescale 1ns/1ns
`default_nettype none

module wh_bram import gat_pkg::*; (
  input  wire logic     clk,
  input  wire logic     rst_n,
  // load port
  input  wire logic     wr_en_i,
  input  wire wh_addr_t wr_addr_i,
  input  wire wh_word_t wr_data_i,
  // read port
  input  wire logic     rd_en_i,
  input  wire wh_addr_t rd_addr_i,
  output wh_word_t      rd_data_o
);

  wh_word_t mem [WH_DEPTH];
  wh_word_t rd_data_q;

  assign rd_data_o = rd_data_q;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // one cycle read latency
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_data_q <= '0;
    end else if (rd_en_i) begin
      rd_data_q <= mem[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

/* verilog/gat_pkg.sv */
`default_nettype none

package gat_pkg;

  // ==================================================
  // element and row widths
  // ==================================================
  localparam int DATA_WIDTH        = 8;
  localparam int HALF_A_SIZE       = 4;
  localparam int A_DEPTH           = 2 * HALF_A_SIZE;
  localparam int WH_DATA_WIDTH     = 8;
  // features plus the source flag in bit 0
  localparam int WH_WIDTH          = HALF_A_SIZE * WH_DATA_WIDTH + 1;

  // ==================================================
  // pipeline
  // ==================================================
  localparam int DMVM_DATA_WIDTH   = 2 * DATA_WIDTH + $clog2(HALF_A_SIZE);
  localparam int NUM_STAGES        = $clog2(HALF_A_SIZE) + 1;
  localparam int COEF_DELAY_LENGTH = NUM_STAGES + 2;

  // ==================================================
  // storage
  // ==================================================
  localparam int WH_DEPTH          = 16;
  localparam int WH_ADDR_WIDTH     = $clog2(WH_DEPTH);
  localparam int COEF_FIFO_DEPTH   = 16;
  localparam int FIFO_ADDR_WIDTH   = $clog2(COEF_FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH    = FIFO_ADDR_WIDTH + 1;
  // room for every row in flight plus slack
  localparam int ISSUE_MARGIN      = COEF_DELAY_LENGTH + 2;

  typedef logic [DATA_WIDTH-1:0]      data_t;
  typedef logic [DMVM_DATA_WIDTH-1:0] acc_t;
  typedef logic [WH_WIDTH-1:0]        wh_word_t;
  typedef logic [WH_ADDR_WIDTH-1:0]   wh_addr_t;
  typedef logic [FIFO_CNT_WIDTH-1:0]  fifo_cnt_t;

  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_DRAIN
  } fetch_state_t;

endpackage

`default_nettype wire
